// ==== common/issue_pkg.sv ====
package issue_pkg;

   // Compute unit geometry
   localparam int WF_PER_CU = 40;
   localparam int WF_ID_LENGTH = 6;

   // Instruction word and address widths
   localparam int OPCODE_LENGTH = 32;
   localparam int PC_LENGTH = 32;

   // Wavefront id, 0 to 39
   typedef logic [WF_ID_LENGTH-1:0] wfid_t;

   // One bit per wavefront
   typedef logic [WF_PER_CU-1:0] wf_mask_t;

   // Functional unit class carried by decode
   typedef enum logic [1:0] {
      FU_SIMD     = 2'd0,
      FU_SALU     = 2'd1,
      FU_LSU      = 2'd2,
      // Former floating point class, never issued
      FU_RESERVED = 2'd3
   } fu_t;

   typedef logic [OPCODE_LENGTH-1:0] opcode_t;

   typedef logic [PC_LENGTH-1:0] pc_t;

endpackage

// ==== wave_state/instr_buffer.sv ====
module instr_buffer
   import issue_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     wr_en,
   input  wfid_t    wr_wfid,
   input  fu_t      wr_fu,
   input  logic     wr_branch,
   input  opcode_t  wr_opcode,
   input  pc_t      wr_pc,
   input  logic     alu_issue,
   input  wfid_t    alu_issue_wfid,
   input  logic     lsu_issue,
   input  wfid_t    lsu_issue_wfid,
   input  logic     flush_en,
   input  wfid_t    flush_wfid,
   output wf_mask_t valid_mask,
   output wf_mask_t fu_simd,
   output wf_mask_t fu_salu,
   output wf_mask_t fu_lsu,
   output opcode_t  alu_opcode,
   output opcode_t  lsu_opcode,
   output pc_t      alu_instr_pc,
   output pc_t      lsu_instr_pc,
   output logic     alu_branch
);

   // Slot contents, one entry per wavefront
   fu_t     fu_mem     [WF_PER_CU];
   logic    branch_mem [WF_PER_CU];
   opcode_t opcode_mem [WF_PER_CU];
   pc_t     pc_mem     [WF_PER_CU];

   // Valid bits; a new write wins over a clear in the same cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_mask <= '0;
      end else begin
         if (alu_issue) begin
            valid_mask[alu_issue_wfid] <= 1'b0;
         end
         if (lsu_issue) begin
            valid_mask[lsu_issue_wfid] <= 1'b0;
         end
         if (flush_en) begin
            valid_mask[flush_wfid] <= 1'b0;
         end
         if (wr_en) begin
            valid_mask[wr_wfid] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         fu_mem[wr_wfid] <= wr_fu;
         branch_mem[wr_wfid] <= wr_branch;
         opcode_mem[wr_wfid] <= wr_opcode;
         pc_mem[wr_wfid] <= wr_pc;
      end
   end

   // Per-class masks, qualified by valid in the arbiter
   always_comb begin
      for (int i = 0; i < WF_PER_CU; i++) begin
         fu_simd[i] = (fu_mem[i] == FU_SIMD);
         fu_salu[i] = (fu_mem[i] == FU_SALU);
         fu_lsu[i] = (fu_mem[i] == FU_LSU);
      end
   end

   // Slot is still held while its select strobe is high
   assign alu_opcode = opcode_mem[alu_issue_wfid];
   assign alu_instr_pc = pc_mem[alu_issue_wfid];
   assign alu_branch = branch_mem[alu_issue_wfid];

   assign lsu_opcode = opcode_mem[lsu_issue_wfid];
   assign lsu_instr_pc = pc_mem[lsu_issue_wfid];

endmodule

// ==== wave_state/wait_tracker.sv ====
module wait_tracker
   import issue_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     alu_issue,
   input  wfid_t    alu_issue_wfid,
   input  logic     alu_branch,
   input  logic     lsu_issue,
   input  wfid_t    lsu_issue_wfid,
   input  logic     branch_done,
   input  wfid_t    branch_done_wfid,
   input  logic     mem_done,
   input  wfid_t    mem_done_wfid,
   output wf_mask_t branch_pending,
   output wf_mask_t mem_pending
);

   // Branch outstanding on the scalar ALU
   always_ff @(posedge clk) begin
      if (rst) begin
         branch_pending <= '0;
      end else begin
         if (branch_done) begin
            branch_pending[branch_done_wfid] <= 1'b0;
         end
         if (alu_issue && alu_branch) begin
            branch_pending[alu_issue_wfid] <= 1'b1;
         end
      end
   end

   // Memory operation outstanding in the LSU
   always_ff @(posedge clk) begin
      if (rst) begin
         mem_pending <= '0;
      end else begin
         if (mem_done) begin
            mem_pending[mem_done_wfid] <= 1'b0;
         end
         if (lsu_issue) begin
            mem_pending[lsu_issue_wfid] <= 1'b1;
         end
      end
   end

endmodule

// ==== arbiter/rr_picker.sv ====
module rr_picker
   import issue_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  wf_mask_t req,
   input  logic     grant,
   output logic     found,
   output wfid_t    pick
);

   // Last granted wavefront
   wfid_t last;

   always_comb begin
      found = 1'b0;
      pick = '0;
      // Lowest request overall covers the wrap case
      for (int i = WF_PER_CU - 1; i >= 0; i--) begin
         if (req[i]) begin
            found = 1'b1;
            pick = wfid_t'(i);
         end
      end
      // Lowest request above the pointer takes precedence
      for (int i = WF_PER_CU - 1; i >= 0; i--) begin
         if (req[i] && (i > int'(last))) begin
            pick = wfid_t'(i);
         end
      end
   end

   // Start at 39 so wavefront 0 is first after reset
   always_ff @(posedge clk) begin
      if (rst) begin
         last <= wfid_t'(WF_PER_CU - 1);
      end else if (grant) begin
         last <= pick;
      end
   end

endmodule

// ==== arbiter/instruction_arbiter.sv ====
module instruction_arbiter
   import issue_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  wf_mask_t valid_mask,
   input  wf_mask_t fu_simd,
   input  wf_mask_t fu_salu,
   input  wf_mask_t fu_lsu,
   input  wf_mask_t branch_pending,
   input  wf_mask_t mem_pending,
   input  logic     simd_ready,
   input  logic     salu_ready,
   input  logic     lsu_ready,
   output logic     salu_select,
   output logic     simd_select,
   output logic     lsu_select,
   output wfid_t    alu_wfid,
   output wfid_t    lsu_wfid
);

   wf_mask_t issued_mask;
   wf_mask_t base_mask;
   wf_mask_t salu_req;
   wf_mask_t simd_req;
   wf_mask_t lsu_req;
   logic     salu_found;
   logic     simd_found;
   logic     lsu_found;
   wfid_t    salu_pick;
   wfid_t    simd_pick;
   wfid_t    lsu_pick;
   logic     simd_grant;

   // Slots on the bus this cycle are cleared only at the next edge
   always_comb begin
      issued_mask = '0;
      if (salu_select || simd_select) begin
         issued_mask[alu_wfid] = 1'b1;
      end
      if (lsu_select) begin
         issued_mask[lsu_wfid] = 1'b1;
      end
   end

   assign base_mask = valid_mask & ~branch_pending & ~issued_mask;

   // A unit that is not ready sees no requests
   assign salu_req = base_mask & fu_salu & {WF_PER_CU{salu_ready}};
   assign simd_req = base_mask & fu_simd & {WF_PER_CU{simd_ready}};
   assign lsu_req = base_mask & fu_lsu & ~mem_pending & {WF_PER_CU{lsu_ready}};

   // Scalar ALU wins the shared bus
   assign simd_grant = simd_found & ~salu_found;

   rr_picker salu_picker_inst (
      .clk   (clk),
      .rst   (rst),
      .req   (salu_req),
      .grant (salu_found),
      .found (salu_found),
      .pick  (salu_pick)
   );

   rr_picker simd_picker_inst (
      .clk   (clk),
      .rst   (rst),
      .req   (simd_req),
      .grant (simd_grant),
      .found (simd_found),
      .pick  (simd_pick)
   );

   rr_picker lsu_picker_inst (
      .clk   (clk),
      .rst   (rst),
      .req   (lsu_req),
      .grant (lsu_found),
      .found (lsu_found),
      .pick  (lsu_pick)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         salu_select <= 1'b0;
         simd_select <= 1'b0;
         lsu_select <= 1'b0;
      end else begin
         salu_select <= salu_found;
         simd_select <= simd_grant;
         lsu_select <= lsu_found;
      end
   end

   always_ff @(posedge clk) begin
      alu_wfid <= salu_found ? salu_pick : simd_pick;
      lsu_wfid <= lsu_pick;
   end

endmodule

// ==== source/issue.sv ====
module issue
   import issue_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    decode_valid,
   input  wfid_t   decode_wfid,
   input  fu_t     decode_fu,
   input  logic    decode_branch,
   input  opcode_t decode_opcode,
   input  pc_t     decode_instr_pc,
   input  logic    simd_ready,
   input  logic    salu_ready,
   input  logic    lsu_ready,
   input  logic    salu_branch_en,
   input  wfid_t   salu_branch_wfid,
   input  logic    salu_branch_taken,
   input  logic    lsu_done,
   input  wfid_t   lsu_done_wfid,
   output logic    salu_select,
   output logic    simd_select,
   output logic    lsu_select,
   output wfid_t   alu_wfid,
   output wfid_t   lsu_wfid,
   output opcode_t alu_opcode,
   output pc_t     alu_instr_pc,
   output opcode_t lsu_opcode,
   output pc_t     lsu_instr_pc
);

   // Flopped inputs
   logic    f_decode_valid;
   wfid_t   f_decode_wfid;
   fu_t     f_decode_fu;
   logic    f_decode_branch;
   opcode_t f_decode_opcode;
   pc_t     f_decode_instr_pc;
   logic    f_simd_ready;
   logic    f_salu_ready;
   logic    f_lsu_ready;
   logic    f_salu_branch_en;
   wfid_t   f_salu_branch_wfid;
   logic    f_salu_branch_taken;
   logic    f_lsu_done;
   wfid_t   f_lsu_done_wfid;

   wf_mask_t valid_mask;
   wf_mask_t fu_simd;
   wf_mask_t fu_salu;
   wf_mask_t fu_lsu;
   wf_mask_t branch_pending;
   wf_mask_t mem_pending;
   logic     alu_issue;
   logic     alu_branch;

   always_ff @(posedge clk) begin
      if (rst) begin
         f_decode_valid <= 1'b0;
         f_simd_ready <= 1'b0;
         f_salu_ready <= 1'b0;
         f_lsu_ready <= 1'b0;
         f_salu_branch_en <= 1'b0;
         f_lsu_done <= 1'b0;
      end else begin
         f_decode_valid <= decode_valid;
         f_simd_ready <= simd_ready;
         f_salu_ready <= salu_ready;
         f_lsu_ready <= lsu_ready;
         f_salu_branch_en <= salu_branch_en;
         f_lsu_done <= lsu_done;
      end
   end

   always_ff @(posedge clk) begin
      f_decode_wfid <= decode_wfid;
      f_decode_fu <= decode_fu;
      f_decode_branch <= decode_branch;
      f_decode_opcode <= decode_opcode;
      f_decode_instr_pc <= decode_instr_pc;
      f_salu_branch_wfid <= salu_branch_wfid;
      f_salu_branch_taken <= salu_branch_taken;
      f_lsu_done_wfid <= lsu_done_wfid;
   end

   assign alu_issue = salu_select | simd_select;

   instr_buffer instr_buffer_inst (
      .clk            (clk),
      .rst            (rst),
      .wr_en          (f_decode_valid),
      .wr_wfid        (f_decode_wfid),
      .wr_fu          (f_decode_fu),
      .wr_branch      (f_decode_branch),
      .wr_opcode      (f_decode_opcode),
      .wr_pc          (f_decode_instr_pc),
      .alu_issue      (alu_issue),
      .alu_issue_wfid (alu_wfid),
      .lsu_issue      (lsu_select),
      .lsu_issue_wfid (lsu_wfid),
      // Taken branch drops the instruction fetched past it
      .flush_en       (f_salu_branch_en & f_salu_branch_taken),
      .flush_wfid     (f_salu_branch_wfid),
      .valid_mask     (valid_mask),
      .fu_simd        (fu_simd),
      .fu_salu        (fu_salu),
      .fu_lsu         (fu_lsu),
      .alu_opcode     (alu_opcode),
      .lsu_opcode     (lsu_opcode),
      .alu_instr_pc   (alu_instr_pc),
      .lsu_instr_pc   (lsu_instr_pc),
      .alu_branch     (alu_branch)
   );

   wait_tracker wait_tracker_inst (
      .clk              (clk),
      .rst              (rst),
      .alu_issue        (alu_issue),
      .alu_issue_wfid   (alu_wfid),
      .alu_branch       (alu_branch),
      .lsu_issue        (lsu_select),
      .lsu_issue_wfid   (lsu_wfid),
      .branch_done      (f_salu_branch_en),
      .branch_done_wfid (f_salu_branch_wfid),
      .mem_done         (f_lsu_done),
      .mem_done_wfid    (f_lsu_done_wfid),
      .branch_pending   (branch_pending),
      .mem_pending      (mem_pending)
   );

   instruction_arbiter instruction_arbiter_inst (
      .clk            (clk),
      .rst            (rst),
      .valid_mask     (valid_mask),
      .fu_simd        (fu_simd),
      .fu_salu        (fu_salu),
      .fu_lsu         (fu_lsu),
      .branch_pending (branch_pending),
      .mem_pending    (mem_pending),
      .simd_ready     (f_simd_ready),
      .salu_ready     (f_salu_ready),
      .lsu_ready      (f_lsu_ready),
      .salu_select    (salu_select),
      .simd_select    (simd_select),
      .lsu_select     (lsu_select),
      .alu_wfid       (alu_wfid),
      .lsu_wfid       (lsu_wfid)
   );

endmodule

// ==== testbench/issue_tb.sv ====
module issue_tb
   import issue_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int MAX_CYCLES = 2000;

   logic    clk = 1'b0;
   logic    rst;
   logic    decode_valid;
   wfid_t   decode_wfid;
   fu_t     decode_fu;
   logic    decode_branch;
   opcode_t decode_opcode;
   pc_t     decode_instr_pc;
   logic    simd_ready;
   logic    salu_ready;
   logic    lsu_ready;
   logic    salu_branch_en;
   wfid_t   salu_branch_wfid;
   logic    salu_branch_taken;
   logic    lsu_done;
   wfid_t   lsu_done_wfid;
   logic    salu_select;
   logic    simd_select;
   logic    lsu_select;
   wfid_t   alu_wfid;
   wfid_t   lsu_wfid;
   opcode_t alu_opcode;
   pc_t     alu_instr_pc;
   opcode_t lsu_opcode;
   pc_t     lsu_instr_pc;

   // Last data sent per wavefront
   opcode_t     exp_opcode [WF_PER_CU];
   pc_t         exp_pc [WF_PER_CU];
   logic [15:0] lfsr_state = 16'd14;
   int          cycle_count = 0;

   issue issue_inst (.*);

   always #2 clk = ~clk;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("=== FAIL ===");
      $fatal(1, "issue_tb stopped");
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         abort_run($sformatf("Run did not finish within %0d cycles", MAX_CYCLES));
      end
   end

   // Taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] random_word();
      logic [31:0] word;
      word = '0;
      for (int i = 0; i < 32; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         word = {word[30:0], lfsr_state[0]};
      end
      return word;
   endfunction

   task automatic check_bit(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected));
      end
   endtask

   task automatic check_wfid(input string name, input wfid_t actual, input wfid_t expected);
      if (actual !== expected) begin
         abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected));
      end
   endtask

   task automatic check_opcode(input string name, input opcode_t actual,
                               input opcode_t expected);
      if (actual !== expected) begin
         abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected));
      end
   endtask

   task automatic check_pc(input string name, input pc_t actual, input pc_t expected);
      if (actual !== expected) begin
         abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected));
      end
   endtask

   task automatic check_alu_data(input wfid_t wfid);
      check_wfid("alu_wfid", alu_wfid, wfid);
      check_opcode("alu_opcode", alu_opcode, exp_opcode[wfid]);
      check_pc("alu_instr_pc", alu_instr_pc, exp_pc[wfid]);
   endtask

   task automatic check_lsu_data(input wfid_t wfid);
      check_wfid("lsu_wfid", lsu_wfid, wfid);
      check_opcode("lsu_opcode", lsu_opcode, exp_opcode[wfid]);
      check_pc("lsu_instr_pc", lsu_instr_pc, exp_pc[wfid]);
   endtask

   // Called on a falling edge, returns on the next one
   task automatic send_instr(input wfid_t wfid, input fu_t fu, input logic branch);
      exp_opcode[wfid] = random_word();
      exp_pc[wfid] = random_word();
      decode_valid = 1'b1;
      decode_wfid = wfid;
      decode_fu = fu;
      decode_branch = branch;
      decode_opcode = exp_opcode[wfid];
      decode_instr_pc = exp_pc[wfid];
      @(negedge clk);
      decode_valid = 1'b0;
   endtask

   task automatic send_branch_result(input wfid_t wfid, input logic taken);
      salu_branch_en = 1'b1;
      salu_branch_wfid = wfid;
      salu_branch_taken = taken;
      @(negedge clk);
      salu_branch_en = 1'b0;
   endtask

   task automatic send_lsu_done(input wfid_t wfid);
      lsu_done = 1'b1;
      lsu_done_wfid = wfid;
      @(negedge clk);
      lsu_done = 1'b0;
   endtask

   // Always moves at least one cycle, so a strobe already seen is skipped
   task automatic wait_alu_issue(input int limit);
      int n;
      n = 0;
      @(negedge clk);
      while (!(salu_select || simd_select)) begin
         n++;
         if (n > limit) begin
            abort_run("No ALU select arrived in time");
         end
         @(negedge clk);
      end
   endtask

   task automatic wait_lsu_issue(input int limit);
      int n;
      n = 0;
      @(negedge clk);
      while (!lsu_select) begin
         n++;
         if (n > limit) begin
            abort_run("No LSU select arrived in time");
         end
         @(negedge clk);
      end
   endtask

   task automatic expect_idle(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         check_bit("salu_select", salu_select, 1'b0);
         check_bit("simd_select", simd_select, 1'b0);
         check_bit("lsu_select", lsu_select, 1'b0);
      end
   endtask

   // Decode at edge E, select high between E+2 and E+3
   task automatic single_issue();
      check_bit("salu_select", salu_select, 1'b0);
      check_bit("simd_select", simd_select, 1'b0);
      check_bit("lsu_select", lsu_select, 1'b0);
      send_instr(wfid_t'(1), FU_SALU, 1'b0);
      check_bit("salu_select", salu_select, 1'b0);
      @(negedge clk);
      check_bit("salu_select", salu_select, 1'b0);
      @(negedge clk);
      check_bit("salu_select", salu_select, 1'b1);
      check_bit("simd_select", simd_select, 1'b0);
      check_alu_data(wfid_t'(1));
      @(negedge clk);
      check_bit("salu_select", salu_select, 1'b0);
   endtask

   task automatic round_robin_order();
      salu_ready = 1'b0;
      simd_ready = 1'b0;
      send_instr(wfid_t'(12), FU_SIMD, 1'b0);
      send_instr(wfid_t'(9), FU_SALU, 1'b0);
      send_instr(wfid_t'(2), FU_SALU, 1'b0);
      send_instr(wfid_t'(5), FU_SALU, 1'b0);
      salu_ready = 1'b1;
      simd_ready = 1'b1;
      wait_alu_issue(10);
      check_bit("salu_select", salu_select, 1'b1);
      check_alu_data(wfid_t'(2));
      wait_alu_issue(10);
      check_bit("salu_select", salu_select, 1'b1);
      check_alu_data(wfid_t'(5));
      wait_alu_issue(10);
      check_bit("salu_select", salu_select, 1'b1);
      check_alu_data(wfid_t'(9));
      wait_alu_issue(10);
      check_bit("simd_select", simd_select, 1'b1);
      check_alu_data(wfid_t'(12));
      // Pointer sits at 9 so 11 comes before the wrap to 3
      salu_ready = 1'b0;
      send_instr(wfid_t'(3), FU_SALU, 1'b0);
      send_instr(wfid_t'(11), FU_SALU, 1'b0);
      salu_ready = 1'b1;
      wait_alu_issue(10);
      check_bit("salu_select", salu_select, 1'b1);
      check_alu_data(wfid_t'(11));
      wait_alu_issue(10);
      check_bit("salu_select", salu_select, 1'b1);
      check_alu_data(wfid_t'(3));
   endtask

   task automatic lsu_back_pressure();
      logic alu_seen;
      alu_seen = 1'b0;
      lsu_ready = 1'b0;
      send_instr(wfid_t'(20), FU_LSU, 1'b0);
      send_instr(wfid_t'(21), FU_SALU, 1'b0);
      repeat (20) begin
         @(negedge clk);
         check_bit("lsu_select", lsu_select, 1'b0);
         if (salu_select) begin
            check_alu_data(wfid_t'(21));
            alu_seen = 1'b1;
         end
      end
      if (!alu_seen) begin
         abort_run("ALU instruction did not issue while the LSU was stalled");
      end
      lsu_ready = 1'b1;
      wait_lsu_issue(10);
      check_lsu_data(wfid_t'(20));
      send_lsu_done(wfid_t'(20));
   endtask

   task automatic branch_wait();
      send_instr(wfid_t'(7), FU_SALU, 1'b1);
      wait_alu_issue(10);
      check_bit("salu_select", salu_select, 1'b1);
      check_alu_data(wfid_t'(7));
      send_instr(wfid_t'(7), FU_SIMD, 1'b0);
      expect_idle(15);
      send_branch_result(wfid_t'(7), 1'b0);
      wait_alu_issue(10);
      check_bit("simd_select", simd_select, 1'b1);
      check_alu_data(wfid_t'(7));
      // Taken branch drops the buffered instruction
      send_instr(wfid_t'(7), FU_SALU, 1'b1);
      wait_alu_issue(10);
      check_bit("salu_select", salu_select, 1'b1);
      check_alu_data(wfid_t'(7));
      send_instr(wfid_t'(7), FU_SIMD, 1'b0);
      expect_idle(10);
      send_branch_result(wfid_t'(7), 1'b1);
      expect_idle(20);
   endtask

   task automatic memory_wait();
      send_instr(wfid_t'(3), FU_LSU, 1'b0);
      wait_lsu_issue(10);
      check_lsu_data(wfid_t'(3));
      send_instr(wfid_t'(3), FU_LSU, 1'b0);
      send_instr(wfid_t'(4), FU_LSU, 1'b0);
      wait_lsu_issue(10);
      check_lsu_data(wfid_t'(4));
      expect_idle(10);
      send_lsu_done(wfid_t'(3));
      wait_lsu_issue(10);
      check_lsu_data(wfid_t'(3));
      send_lsu_done(wfid_t'(3));
      send_lsu_done(wfid_t'(4));
   endtask

   initial begin
      rst = 1'b1;
      decode_valid = 1'b0;
      decode_wfid = '0;
      decode_fu = FU_SIMD;
      decode_branch = 1'b0;
      decode_opcode = '0;
      decode_instr_pc = '0;
      simd_ready = 1'b1;
      salu_ready = 1'b1;
      lsu_ready = 1'b1;
      salu_branch_en = 1'b0;
      salu_branch_wfid = '0;
      salu_branch_taken = 1'b0;
      lsu_done = 1'b0;
      lsu_done_wfid = '0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      single_issue();
      round_robin_order();
      lsu_back_pressure();
      branch_wait();
      memory_wait();
      $display("=== PASS ===");
      $finish;
   end

endmodule

// ==== vlog.f ====
common/issue_pkg.sv
wave_state/instr_buffer.sv
wave_state/wait_tracker.sv
arbiter/rr_picker.sv
arbiter/instruction_arbiter.sv
source/issue.sv
testbench/issue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the issue stage testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" \
   && verilator --binary --timing --timescale 1ns/100ps \
      -f vlog.f --top-module issue_tb -o issue_sim \
   && ./obj_dir/issue_sim | tee /dev/stderr | grep -q -x -F "=== PASS ===" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
